// ==== Bender.yml ====
package:
  name: uart_periph

sources:
  - files:
      - logic/uart_pkg.sv
      - logic/uart_regs.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/uart_status.sv
      - logic/uart_top.sv
  - target: simulation
    files:
      - test/uart_checker.sv
      - test/tb_uart.sv

// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    //////////////////////////////////////////////////
    // Register map

    localparam logic [1:0] addr_data    = 2'd0;  // Write sends, read returns rx byte
    localparam logic [1:0] addr_status  = 2'd1;
    localparam logic [1:0] addr_ctrl    = 2'd2;
    localparam logic [1:0] addr_divisor = 2'd3;

    // CTRL bit positions
    localparam int ctrl_tx_en       = 0;
    localparam int ctrl_rx_en       = 1;
    localparam int ctrl_parity_en   = 2;
    localparam int ctrl_even_parity = 3;
    localparam int ctrl_two_stop    = 4;

    // STATUS bit positions
    localparam int st_tx_idle    = 0;
    localparam int st_rx_valid   = 1;
    localparam int st_err_frame  = 2;
    localparam int st_err_parity = 3;
    localparam int st_overrun    = 4;
    localparam int st_rx_parity  = 5;  // Parity bit of the last frame

    //////////////////////////////////////////////////
    // Parity bit that goes with a byte
    // Even mode gives an even count of ones over data and parity

    function automatic logic parity_bit(input logic [7:0] data, input logic even);
        logic ones_odd;
        ones_odd = ^data;
        return even ? ones_odd : ~ones_odd;
    endfunction

endpackage

`default_nettype wire

// ==== logic/uart_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_regs
    import uart_pkg::*;
#(
    parameter int div_width = 16
) (
    input  logic                 clk,
    input  logic                 rst,

    // Register bus
    input  logic                 bus_we,
    input  logic                 bus_re,
    input  logic [1:0]           bus_addr,
    input  logic [31:0]          bus_wdata,

    // Frame configuration
    output logic                 tx_en,
    output logic                 rx_en,
    output logic                 parity_en,
    output logic                 even_parity,
    output logic                 two_stop,
    output logic [div_width-1:0] divisor,

    // Strobes
    output logic                 tx_start,
    output logic [7:0]           tx_data,
    output logic                 data_read
);

    logic [4:0] ctrl_q;

    //////////////////////////////////////////////////
    // CTRL and DIVISOR registers

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q  <= '0;
            divisor <= '0;
        end else if (bus_we) begin
            if (bus_addr == addr_ctrl)
                ctrl_q <= bus_wdata[4:0];
            if (bus_addr == addr_divisor)
                divisor <= bus_wdata[div_width-1:0];
        end
    end

    assign tx_en       = ctrl_q[ctrl_tx_en];
    assign rx_en       = ctrl_q[ctrl_rx_en];
    assign parity_en   = ctrl_q[ctrl_parity_en];
    assign even_parity = ctrl_q[ctrl_even_parity];
    assign two_stop    = ctrl_q[ctrl_two_stop];

    //////////////////////////////////////////////////
    // DATA access strobes
    // The transmitter decides itself whether it takes the byte

    assign tx_start  = bus_we && (bus_addr == addr_data);
    assign tx_data   = bus_wdata[7:0];
    assign data_read = bus_re && (bus_addr == addr_data);  // Consumes rx buffer

endmodule

`default_nettype wire

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_rx
    import uart_pkg::*;
#(
    parameter int div_width = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_en,
    input  logic                 parity_en,
    input  logic                 even_parity,
    input  logic                 two_stop,
    input  logic [div_width-1:0] divisor,
    input  logic                 ser_rx,
    output logic                 rx_done,
    output logic [7:0]           rx_data,
    output logic                 rx_parity,
    output logic                 rx_err_parity,
    output logic                 rx_err_frame
);

    localparam logic [2:0] s_idle   = 3'd0;
    localparam logic [2:0] s_start  = 3'd1;
    localparam logic [2:0] s_data   = 3'd2;
    localparam logic [2:0] s_parity = 3'd3;
    localparam logic [2:0] s_stop   = 3'd4;

    logic               rx_meta;
    logic               rx_s;       // Synchronized line
    logic [2:0]         state;
    logic [div_width:0] cnt;
    logic [2:0]         bit_idx;
    logic               second_stop;
    logic               half_done;
    logic               bit_done;

    assign half_done = {cnt, 1'b0} > divisor;   // Middle of the start bit
    assign bit_done  = cnt > {1'b0, divisor};

    //////////////////////////////////////////////////
    // Two-flop synchronizer, idles high

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= ser_rx;
            rx_s    <= rx_meta;
        end
    end

    //////////////////////////////////////////////////
    // Frame FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= s_idle;
            cnt           <= '0;
            bit_idx       <= '0;
            second_stop   <= 1'b0;
            rx_done       <= 1'b0;
            rx_parity     <= 1'b0;
            rx_err_parity <= 1'b0;
            rx_err_frame  <= 1'b0;
        end else begin
            rx_done <= 1'b0;
            cnt     <= cnt + 1'b1;
            case (state)
                s_idle: begin
                    cnt <= '0;
                    if (rx_en && !rx_s)
                        state <= s_start;
                end
                s_start: begin
                    if (half_done) begin
                        cnt <= '0;
                        if (rx_s) begin
                            state <= s_idle;    // Glitch, not a start bit
                        end else begin
                            rx_parity     <= 1'b0;
                            rx_err_parity <= 1'b0;
                            rx_err_frame  <= 1'b0;
                            bit_idx       <= '0;
                            second_stop   <= 1'b0;
                            state         <= s_data;
                        end
                    end
                end
                s_data: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        rx_data <= {rx_s, rx_data[7:1]};  // LSB first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= parity_en ? s_parity : s_stop;
                    end
                end
                s_parity: begin
                    if (bit_done) begin
                        cnt           <= '0;
                        rx_parity     <= rx_s;
                        rx_err_parity <= rx_s != parity_bit(rx_data, even_parity);
                        state         <= s_stop;
                    end
                end
                s_stop: begin
                    if (bit_done) begin
                        cnt <= '0;
                        if (!rx_s) begin
                            // Low stop bit ends the frame right here
                            rx_err_frame <= 1'b1;
                            rx_done      <= 1'b1;
                            state        <= s_idle;
                        end else if (two_stop && !second_stop) begin
                            second_stop <= 1'b1;
                        end else begin
                            rx_done <= 1'b1;
                            state   <= s_idle;
                        end
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_status.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_status
    import uart_pkg::*;
#(
    parameter int div_width = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 bus_we,
    input  logic                 bus_re,
    input  logic [1:0]           bus_addr,
    input  logic                 data_read,
    input  logic                 tx_idle,
    input  logic                 rx_done,
    input  logic [7:0]           rx_data,
    input  logic                 rx_parity,
    input  logic                 rx_err_parity,
    input  logic                 rx_err_frame,
    input  logic [4:0]           ctrl_word,
    input  logic [div_width-1:0] divisor,
    output logic [31:0]          bus_rdata
);

    logic [7:0] rx_buf;
    logic       rx_valid;
    logic       overrun;
    logic       err_frame;
    logic       err_parity;
    logic       last_parity;
    logic [5:0] status_word;

    //////////////////////////////////////////////////
    // Receive buffer and flags

    always_ff @(posedge clk) begin
        if (rx_done && !rx_err_frame)
            rx_buf <= rx_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid    <= 1'b0;
            overrun     <= 1'b0;
            err_frame   <= 1'b0;
            err_parity  <= 1'b0;
            last_parity <= 1'b0;
        end else begin
            if (data_read)
                rx_valid <= 1'b0;
            if (bus_we && bus_addr == addr_status)
                overrun <= 1'b0;
            if (rx_done) begin
                err_frame   <= rx_err_frame;    // Replaced every frame
                err_parity  <= rx_err_parity;
                last_parity <= rx_parity;
                if (rx_valid)
                    overrun <= 1'b1;            // Unread byte is lost
                if (!rx_err_frame)
                    rx_valid <= 1'b1;
            end
        end
    end

    always_comb begin
        status_word                = '0;
        status_word[st_tx_idle]    = tx_idle;
        status_word[st_rx_valid]   = rx_valid;
        status_word[st_err_frame]  = err_frame;
        status_word[st_err_parity] = err_parity;
        status_word[st_overrun]    = overrun;
        status_word[st_rx_parity]  = last_parity;
    end

    // Read data, held until the next read
    always_ff @(posedge clk) begin
        if (rst) begin
            bus_rdata <= '0;
        end else if (bus_re) begin
            bus_rdata <= '0;
            case (bus_addr)
                addr_data:    bus_rdata[7:0]           <= rx_buf;
                addr_status:  bus_rdata[5:0]           <= status_word;
                addr_ctrl:    bus_rdata[4:0]           <= ctrl_word;
                addr_divisor: bus_rdata[div_width-1:0] <= divisor;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/uart_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_top #(
    parameter int div_width = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        bus_we,
    input  logic        bus_re,
    input  logic [1:0]  bus_addr,
    input  logic [31:0] bus_wdata,
    output logic [31:0] bus_rdata,
    output logic        ser_tx,
    input  logic        ser_rx
);

    logic                 tx_en;
    logic                 rx_en;
    logic                 parity_en;
    logic                 even_parity;
    logic                 two_stop;
    logic [div_width-1:0] divisor;
    logic                 tx_start;
    logic [7:0]           tx_data;
    logic                 data_read;
    logic                 tx_idle;
    logic                 rx_done;
    logic [7:0]           rx_data;
    logic                 rx_parity;
    logic                 rx_err_parity;
    logic                 rx_err_frame;

    //////////////////////////////////////////////////
    // Decode

    uart_regs #(.div_width(div_width)) i_regs (
        .clk         (clk),
        .rst         (rst),
        .bus_we      (bus_we),
        .bus_re      (bus_re),
        .bus_addr    (bus_addr),
        .bus_wdata   (bus_wdata),
        .tx_en       (tx_en),
        .rx_en       (rx_en),
        .parity_en   (parity_en),
        .even_parity (even_parity),
        .two_stop    (two_stop),
        .divisor     (divisor),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .data_read   (data_read)
    );

    //////////////////////////////////////////////////
    // Serial engines

    uart_tx #(.div_width(div_width)) i_tx (
        .clk         (clk),
        .rst         (rst),
        .tx_en       (tx_en),
        .parity_en   (parity_en),
        .even_parity (even_parity),
        .two_stop    (two_stop),
        .divisor     (divisor),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .ser_tx      (ser_tx),
        .tx_idle     (tx_idle)
    );

    uart_rx #(.div_width(div_width)) i_rx (
        .clk           (clk),
        .rst           (rst),
        .rx_en         (rx_en),
        .parity_en     (parity_en),
        .even_parity   (even_parity),
        .two_stop      (two_stop),
        .divisor       (divisor),
        .ser_rx        (ser_rx),
        .rx_done       (rx_done),
        .rx_data       (rx_data),
        .rx_parity     (rx_parity),
        .rx_err_parity (rx_err_parity),
        .rx_err_frame  (rx_err_frame)
    );

    //////////////////////////////////////////////////
    // Result

    uart_status #(.div_width(div_width)) i_status (
        .clk           (clk),
        .rst           (rst),
        .bus_we        (bus_we),
        .bus_re        (bus_re),
        .bus_addr      (bus_addr),
        .data_read     (data_read),
        .tx_idle       (tx_idle),
        .rx_done       (rx_done),
        .rx_data       (rx_data),
        .rx_parity     (rx_parity),
        .rx_err_parity (rx_err_parity),
        .rx_err_frame  (rx_err_frame),
        // Same bit order as the CTRL register
        .ctrl_word     ({two_stop, even_parity, parity_en, rx_en, tx_en}),
        .divisor       (divisor),
        .bus_rdata     (bus_rdata)
    );

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx
    import uart_pkg::*;
#(
    parameter int div_width = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 tx_en,
    input  logic                 parity_en,
    input  logic                 even_parity,
    input  logic                 two_stop,
    input  logic [div_width-1:0] divisor,
    input  logic                 tx_start,
    input  logic [7:0]           tx_data,
    output logic                 ser_tx,
    output logic                 tx_idle
);

    localparam logic [2:0] s_idle   = 3'd0;
    localparam logic [2:0] s_start  = 3'd1;
    localparam logic [2:0] s_data   = 3'd2;
    localparam logic [2:0] s_parity = 3'd3;
    localparam logic [2:0] s_stop   = 3'd4;

    logic [2:0]         state;
    logic [div_width:0] cnt;        // One bit wider than divisor
    logic [2:0]         bit_idx;
    logic               second_stop;
    logic [8:0]         pattern;    // Parity on top of the byte
    logic               bit_done;

    // Bit period is divisor+2 cycles
    assign bit_done = cnt > {1'b0, divisor};
    assign tx_idle  = (state == s_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= s_idle;
            cnt         <= '0;
            bit_idx     <= '0;
            second_stop <= 1'b0;
            ser_tx      <= 1'b1;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                s_idle: begin
                    cnt <= '0;
                    if (tx_start && tx_en) begin
                        pattern <= {parity_bit(tx_data, even_parity), tx_data};
                        ser_tx  <= 1'b0;    // Start bit on the next cycle
                        state   <= s_start;
                    end
                end
                s_start: begin
                    if (bit_done) begin
                        cnt         <= '0;
                        ser_tx      <= pattern[0];
                        pattern     <= pattern >> 1;
                        bit_idx     <= '0;
                        second_stop <= 1'b0;
                        state       <= s_data;
                    end
                end
                s_data: begin
                    if (bit_done) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            // Only the parity bit is left in the pattern
                            if (parity_en) begin
                                ser_tx <= pattern[0];
                                state  <= s_parity;
                            end else begin
                                ser_tx <= 1'b1;
                                state  <= s_stop;
                            end
                        end else begin
                            ser_tx  <= pattern[0];
                            pattern <= pattern >> 1;
                        end
                    end
                end
                s_parity: begin
                    if (bit_done) begin
                        cnt    <= '0;
                        ser_tx <= 1'b1;
                        state  <= s_stop;
                    end
                end
                s_stop: begin
                    if (bit_done) begin
                        cnt <= '0;
                        if (two_stop && !second_stop)
                            second_stop <= 1'b1;    // Line stays high
                        else
                            state <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/uart_pkg.sv
logic/uart_regs.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_status.sv
logic/uart_top.sv
test/uart_checker.sv
test/tb_uart.sv

// ==== test/tb_uart.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_uart
    import uart_pkg::*;
();

    localparam int clk_period    = 10;
    localparam int div_value     = 6;
    localparam int bit_cycles    = div_value + 2;
    localparam int n_bytes       = 15;      // Frames sent plus the quiet window
    localparam int margin_cycles = 3000;
    localparam int timeout_ns    = (n_bytes * 12 * bit_cycles + margin_cycles) * clk_period;
    localparam int poll_limit    = 12 * bit_cycles;

    logic        clk = 1'b0;
    logic        rst;
    logic        bus_we;
    logic        bus_re;
    logic [1:0]  bus_addr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        ser_tx;
    logic        ser_rx;
    logic        ser_drv;
    logic        loopback;
    logic        check_en;
    logic [31:0] exp_value;
    logic        quiet_check;
    logic        test_end;
    logic        run_end;
    int          test_num;
    int          tb_fail;
    int          error_count;
    integer      seed;
    logic        par_en;
    logic        even_par;
    logic        two_stop;
    logic [7:0]  byte_a;
    logic [7:0]  byte_b;
    logic [31:0] rd;
    logic [13:0] exp;
    int          i;

    assign ser_rx = loopback ? ser_tx : ser_drv;

    always #(clk_period / 2) clk = ~clk;

    uart_top #(.div_width(16)) i_dut (
        .clk       (clk),
        .rst       (rst),
        .bus_we    (bus_we),
        .bus_re    (bus_re),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .ser_tx    (ser_tx),
        .ser_rx    (ser_rx)
    );

    uart_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .bus_re      (bus_re),
        .bus_addr    (bus_addr),
        .bus_rdata   (bus_rdata),
        .ser_tx      (ser_tx),
        .check_en    (check_en),
        .exp_value   (exp_value),
        .quiet_check (quiet_check),
        .test_end    (test_end),
        .run_end     (run_end),
        .test_num    (test_num),
        .other_fails (tb_fail),
        .error_count (error_count)
    );

    //////////////////////////////////////////////////
    // Expected DATA byte in [7:0] and STATUS bits in [13:8]

    function automatic logic [13:0] expected_frame(input logic [7:0] sent, input logic p_en,
                                                   input logic even, input logic flip,
                                                   input logic bad_stop, input logic unread);
        logic       ones;
        logic       par;
        logic [5:0] st;
        ones = 1'b0;
        for (int k = 0; k < 8; k++)
            ones = ones ^ sent[k];
        par = even ? ones : !ones;     // Even mode keeps the count of ones even
        st = '0;
        st[st_tx_idle]    = 1'b1;
        st[st_rx_valid]   = !bad_stop;
        st[st_err_frame]  = bad_stop;
        st[st_err_parity] = p_en && flip;
        st[st_overrun]    = unread;
        st[st_rx_parity]  = p_en ? (par ^ flip) : 1'b0;
        return {st, sent};
    endfunction

    //////////////////////////////////////////////////
    // Bus and serial tasks

    task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        bus_we    <= 1'b1;
        bus_addr  <= addr;
        bus_wdata <= data;
        @(posedge clk);
        bus_we    <= 1'b0;
    endtask

    // Read data is on bus_rdata from the cycle after the strobe
    task automatic bus_read(input logic [1:0] addr, input logic chk, input logic [31:0] expect_val,
                            output logic [31:0] val);
        @(posedge clk);
        bus_re    <= 1'b1;
        bus_addr  <= addr;
        check_en  <= chk;
        exp_value <= expect_val;
        @(posedge clk);
        bus_re   <= 1'b0;
        check_en <= 1'b0;
        @(posedge clk);
        val = bus_rdata;
    endtask

    task automatic wait_status(input logic [5:0] mask);
        logic [31:0] val;
        int          polls;
        val   = '0;
        polls = 0;
        while ((val[5:0] & mask) != mask && polls < poll_limit) begin
            bus_read(addr_status, 1'b0, '0, val);
            polls++;
        end
        if ((val[5:0] & mask) != mask) begin
            $display("Test %0d gave up waiting for STATUS bits %b", test_num, mask);
            tb_fail++;
        end
    endtask

    task automatic set_ctrl(input logic [4:0] value);
        bus_write(addr_ctrl, {27'b0, value});
        par_en   = value[ctrl_parity_en];
        even_par = value[ctrl_even_parity];
        two_stop = value[ctrl_two_stop];
    endtask

    task automatic next_byte(output logic [7:0] b);
        logic [31:0] r;
        r = $random(seed);
        b = r[7:0];
    endtask

    task automatic send_bit(input logic v);
        @(posedge clk);
        ser_drv <= v;
        repeat (bit_cycles - 1) @(posedge clk);
    endtask

    // Frame on ser_rx with optional parity or stop bit faults
    task automatic drive_frame(input logic [7:0] b, input logic flip, input logic bad_stop);
        logic [13:0] ref_val;
        ref_val = expected_frame(b, par_en, even_par, flip, 1'b0, 1'b0);
        send_bit(1'b0);
        for (int k = 0; k < 8; k++)
            send_bit(b[k]);
        if (par_en)
            send_bit(ref_val[8 + st_rx_parity]);
        send_bit(!bad_stop);
        if (two_stop && !bad_stop)
            send_bit(1'b1);
        @(posedge clk);
        ser_drv <= 1'b1;
    endtask

    task automatic loopback_byte(input logic [7:0] b);
        logic [13:0] e;
        bus_write(addr_data, {24'b0, b});
        wait_status(6'b1 << st_tx_idle | 6'b1 << st_rx_valid);
        e = expected_frame(b, par_en, even_par, 1'b0, 1'b0, 1'b0);
        bus_read(addr_status, 1'b1, {26'b0, e[13:8]}, rd);
        bus_read(addr_data, 1'b1, {24'b0, e[7:0]}, rd);
        bus_read(addr_status, 1'b1, {26'b0, e[13:8] & ~(6'b1 << st_rx_valid)}, rd);
    endtask

    task automatic end_test();
        @(posedge clk);
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
        test_num <= test_num + 1;
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        seed        = 94446;
        rst         = 1'b1;
        bus_we      = 1'b0;
        bus_re      = 1'b0;
        bus_addr    = '0;
        bus_wdata   = '0;
        ser_drv     = 1'b1;
        loopback    = 1'b1;
        check_en    = 1'b0;
        exp_value   = '0;
        quiet_check = 1'b0;
        test_end    = 1'b0;
        run_end     = 1'b0;
        test_num    = 1;
        tb_fail     = 0;
        par_en      = 1'b0;
        even_par    = 1'b0;
        two_stop    = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Reset values and read-back
        bus_read(addr_status, 1'b1, 32'h1, rd);
        bus_read(addr_ctrl, 1'b1, 32'h0, rd);
        bus_read(addr_divisor, 1'b1, 32'h0, rd);
        set_ctrl(5'h1b);
        bus_read(addr_ctrl, 1'b1, 32'h1b, rd);
        bus_write(addr_divisor, 32'hbeef);
        bus_read(addr_divisor, 1'b1, 32'hbeef, rd);
        bus_write(addr_divisor, div_value);
        bus_read(addr_divisor, 1'b1, div_value, rd);
        end_test();

        set_ctrl(5'h03);       // Both engines on, no parity
        for (i = 0; i < 4; i++) begin
            next_byte(byte_a);
            loopback_byte(byte_a);
        end
        end_test();

        // Even/one stop, odd/two stop, even/two stop
        set_ctrl(5'h0f);
        for (i = 0; i < 2; i++) begin
            next_byte(byte_a);
            loopback_byte(byte_a);
        end
        set_ctrl(5'h17);
        for (i = 0; i < 2; i++) begin
            next_byte(byte_a);
            loopback_byte(byte_a);
        end
        set_ctrl(5'h1f);
        for (i = 0; i < 2; i++) begin
            next_byte(byte_a);
            loopback_byte(byte_a);
        end
        end_test();

        // Faults injected on ser_rx
        set_ctrl(5'h0f);
        loopback <= 1'b0;
        next_byte(byte_a);
        drive_frame(byte_a, 1'b1, 1'b0);
        wait_status(6'b1 << st_rx_valid);
        exp = expected_frame(byte_a, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        bus_read(addr_status, 1'b1, {26'b0, exp[13:8]}, rd);
        bus_read(addr_data, 1'b1, {24'b0, exp[7:0]}, rd);
        next_byte(byte_b);
        drive_frame(byte_b, 1'b0, 1'b1);
        wait_status(6'b1 << st_err_frame);
        exp = expected_frame(byte_b, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
        bus_read(addr_status, 1'b1, {26'b0, exp[13:8]}, rd);
        loopback <= 1'b1;
        end_test();

        // Overrun, clear, then a dropped write
        set_ctrl(5'h03);
        next_byte(byte_a);
        next_byte(byte_b);
        bus_write(addr_data, {24'b0, byte_a});
        wait_status(6'b1 << st_tx_idle | 6'b1 << st_rx_valid);
        bus_write(addr_data, {24'b0, byte_b});
        wait_status(6'b1 << st_tx_idle | 6'b1 << st_overrun);
        exp = expected_frame(byte_b, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
        bus_read(addr_status, 1'b1, {26'b0, exp[13:8]}, rd);
        bus_read(addr_data, 1'b1, {24'b0, exp[7:0]}, rd);
        bus_write(addr_status, 32'h0);
        bus_read(addr_status, 1'b1, 32'h1, rd);
        set_ctrl(5'h02);
        quiet_check <= 1'b1;
        bus_write(addr_data, {24'b0, byte_a});
        bus_read(addr_status, 1'b1, 32'h1, rd);    // Transmitter still idle
        repeat (12 * bit_cycles) @(posedge clk);   // One full frame time
        quiet_check <= 1'b0;
        bus_read(addr_status, 1'b1, 32'h1, rd);
        end_test();

        @(posedge clk);
        run_end <= 1'b1;
        @(posedge clk);
        run_end <= 1'b0;
        @(posedge clk);
        if (error_count == 0 && tb_fail == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

    // Watchdog
    initial begin
        #(timeout_ns);
        $display("Simulation timed out after %0d ns before the tests finished", timeout_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/uart_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        bus_re,
    input  logic [1:0]  bus_addr,
    input  logic [31:0] bus_rdata,
    input  logic        ser_tx,
    input  logic        check_en,
    input  logic [31:0] exp_value,
    input  logic        quiet_check,
    input  logic        test_end,
    input  logic        run_end,
    input  int          test_num,
    input  int          other_fails,
    output int          error_count
);

    logic        pend;
    logic [31:0] exp_q;
    logic [1:0]  addr_q;
    logic        quiet_prev;
    logic        quiet_flag;    // One report per quiet window
    int          checks;
    int          test_checks;
    int          test_errors;

    initial begin
        checks      = 0;
        test_checks = 0;
        test_errors = 0;
        error_count = 0;
    end

    //////////////////////////////////////////////////
    // Read compare, one cycle after the strobe

    always @(posedge clk) begin
        if (rst) begin
            pend       <= 1'b0;
            quiet_prev <= 1'b0;
            quiet_flag <= 1'b0;
        end else begin
            if (pend) begin
                checks++;
                test_checks++;
                if (bus_rdata !== exp_q) begin
                    error_count++;
                    test_errors++;
                    $display("[ERROR] %0t ns: register %0d read %h, expected %h",
                             $time, addr_q, bus_rdata, exp_q);
                end
            end
            pend   <= bus_re && check_en;
            exp_q  <= exp_value;
            addr_q <= bus_addr;

            // Serial line must stay idle while the window is open
            if (quiet_check && ser_tx !== 1'b1 && !quiet_flag) begin
                error_count++;
                test_errors++;
                quiet_flag <= 1'b1;
                $display("[ERROR] %0t ns: ser_tx left idle with the transmitter disabled",
                         $time);
            end
            if (quiet_prev && !quiet_check) begin
                checks++;
                test_checks++;
                quiet_flag <= 1'b0;
            end
            quiet_prev <= quiet_check;

            if (test_end) begin
                $display("Test %0d done: %0d checks, %0d errors",
                         test_num, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            if (run_end)
                $display("All tests: %0d checks, %0d errors, %0d other failures",
                         checks, error_count, other_fails);
        end
    end

endmodule

`default_nettype wire
